//--- matrix_echo.f
+incdir+src
src/matrix_pkg.sv
src/matrix_bus_if.sv
src/uart_rx.sv
src/uart_tx.sv
src/mode_controller.sv
src/matrix_parser.sv
src/matrix_store.sv
src/matrix_printer.sv
src/matrix_echo_top.sv
verif/matrix_echo_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary -f matrix_echo.f --top-module matrix_echo_tb -o matrix_echo_sim || exit 1
out=$(./obj_dir/matrix_echo_sim)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }

//--- src/matrix_bus_if.sv
// carries one complete matrix from the parser to the store and the printer
`timescale 1ns/10ps

interface matrix_bus_if;
	import matrix_pkg::*;

	logic    valid; // one-clock strobe, matrix complete
	dim_t    m;     // rows
	dim_t    n;     // cols
	matrix_t data;  // row-major elements

	modport src (output valid, output m, output n, output data);
	modport dst (input valid, input m, input n, input data);

endinterface

//--- src/matrix_echo_top.sv
// top level of the matrix data-entry echo path, uart in and out plus status leds
`timescale 1ns/10ps

module matrix_echo_top (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [2:0] command,
	input  logic       btn_confirm,
	input  logic       btn_exit,
	input  logic       uart_rxd,
	output logic       uart_txd,
	output logic [7:0] led,
	output logic [7:0] ld2
);
	import matrix_pkg::*;

	logic       rx_done;
	elem_t      rx_data;
	mode_t      mode;
	logic       parse_error;
	logic       tx_start;
	elem_t      tx_data;
	logic       tx_busy;
	logic [1:0] stored_count;
	logic       store_blink;
	logic       error_blink;

	matrix_bus_if mbus ();

	// ============================================================
	// receive, parse, store, echo
	// ============================================================
	uart_rx u_uart_rx (
		.clk     (clk),
		.rst_n   (rst_n),
		.rxd     (uart_rxd),
		.rx_done (rx_done),
		.rx_data (rx_data)
	);

	mode_controller u_mode (
		.clk         (clk),
		.rst_n       (rst_n),
		.command     (command),
		.btn_confirm (btn_confirm),
		.btn_exit    (btn_exit),
		.mode        (mode)
	);

	matrix_parser u_parser (
		.clk         (clk),
		.rst_n       (rst_n),
		.mode        (mode),
		.rx_done     (rx_done),
		.rx_data     (rx_data),
		.mbus        (mbus.src),
		.parse_error (parse_error)
	);

	matrix_store u_store (
		.clk          (clk),
		.rst_n        (rst_n),
		.mbus         (mbus.dst),
		.parse_error  (parse_error),
		.stored_count (stored_count),
		.store_blink  (store_blink),
		.error_blink  (error_blink)
	);

	matrix_printer u_printer (
		.clk      (clk),
		.rst_n    (rst_n),
		.mbus     (mbus.dst),
		.tx_busy  (tx_busy),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.done     ()             // end of echo, not needed here
	);

	uart_tx u_uart_tx (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.txd      (uart_txd),
		.busy     (tx_busy)
	);

	// registered leds: led[5] data input, ld2 = count, error, store
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led <= 8'h00;
			ld2 <= 8'h00;
		end else begin
			led <= {2'b00, mode == mode_data_input, 5'b00000};
			ld2 <= {4'b0000, stored_count, error_blink, store_blink};
		end
	end

endmodule

//--- src/matrix_parser.sv
// turns the ascii digit stream "m n e.." into a checked matrix on the bus
`timescale 1ns/10ps
`include "matrix_settings.svh"

module matrix_parser (
	input  logic               clk,
	input  logic               rst_n,
	input  matrix_pkg::mode_t  mode,
	input  logic               rx_done,
	input  matrix_pkg::elem_t  rx_data,
	matrix_bus_if.src          mbus,
	output logic               parse_error
);
	import matrix_pkg::*;

	typedef enum logic [1:0] {st_m, st_n, st_elem} state_t;

	state_t     state;
	logic [4:0] elem_idx;  // running r*n+c
	logic [4:0] total;     // m*n, at most 25
	logic       active;
	logic       is_digit;
	logic       is_sep;
	logic [3:0] digit;
	logic       dim_ok;
	logic       elem_bad;
	logic       accept;

	assign active   = (mode == mode_data_input);
	assign is_digit = (rx_data >= 8'h30) && (rx_data <= 8'h39);
	assign is_sep   = (rx_data == 8'h20) || (rx_data == 8'h0d) || (rx_data == 8'h0a);
	assign digit    = rx_data[3:0];                 // '0' is 8'h30
	assign dim_ok   = (digit >= 4'd1) && (digit <= 4'(`MAX_DIM));
	assign elem_bad = digit > 4'(`ELEM_MAX);
	assign accept   = active && rx_done && is_digit;

	// ============================================================
	// control FSM
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= st_m;
			elem_idx    <= '0;
			mbus.valid  <= 1'b0;
			parse_error <= 1'b0;
		end else begin
			mbus.valid  <= 1'b0;
			parse_error <= 1'b0;
			if (!active) begin
				state    <= st_m;                   // mode left, start over
				elem_idx <= '0;
			end else if (rx_done && !is_sep) begin
				if (!is_digit) begin
					parse_error <= 1'b1;             // stray character
					state       <= st_m;
				end else begin
					case (state)
						st_m: begin
							if (dim_ok)
								state <= st_n;
							else
								parse_error <= 1'b1;
						end
						st_n: begin
							elem_idx <= '0;
							if (dim_ok)
								state <= st_elem;
							else begin
								parse_error <= 1'b1;
								state       <= st_m;
							end
						end
						st_elem: begin
							if (elem_bad) begin
								parse_error <= 1'b1;
								state       <= st_m;
							end else if (elem_idx == total - 5'd1) begin
								mbus.valid <= 1'b1;    // last element
								state      <= st_m;
							end else
								elem_idx <= elem_idx + 5'd1;
						end
						default: state <= st_m;
					endcase
				end
			end
		end
	end

	// payload, only meaningful once valid pulses
	always_ff @(posedge clk) begin
		if (accept) begin
			case (state)
				st_m: mbus.m <= digit[2:0];
				st_n: begin
					mbus.n <= digit[2:0];
					total  <= {2'b0, mbus.m} * {2'b0, digit[2:0]};
				end
				st_elem: mbus.data[elem_idx] <= elem_t'(digit);  // digit value, not ascii
				default: ;
			endcase
		end
	end

endmodule

//--- src/matrix_pkg.sv
// element, dimension, matrix and mode types shared across the matrix echo design
`include "matrix_settings.svh"

package matrix_pkg;

	// one matrix element, also one uart byte
	typedef logic [7:0] elem_t;

	// row or column count, 1..MAX_DIM
	typedef logic [2:0] dim_t;

	// row-major, element r*n+c at index r*n+c, packed from 0
	typedef elem_t [`MAX_DIM*`MAX_DIM-1:0] matrix_t;

	// operating mode latched by the confirm button
	typedef enum logic [1:0] {
		mode_idle       = 2'd0,
		mode_data_input = 2'd1
	} mode_t;

endpackage

//--- src/matrix_printer.sv
// echoes a captured matrix as ascii rows ("d d d" CR LF) through the uart transmitter
`timescale 1ns/10ps

module matrix_printer (
	input  logic               clk,
	input  logic               rst_n,
	matrix_bus_if.dst          mbus,
	input  logic               tx_busy,
	output logic               tx_start,
	output matrix_pkg::elem_t  tx_data,
	output logic               done
);
	import matrix_pkg::*;

	typedef enum logic [1:0] {st_idle, st_send, st_wait_hi} state_t;
	typedef enum logic [1:0] {ph_digit, ph_space, ph_cr, ph_lf} phase_t;

	state_t     state;
	phase_t     phase;     // which byte goes out next
	matrix_t    mat;
	dim_t       dim_m;
	dim_t       dim_n;
	dim_t       row;
	dim_t       col;
	logic [4:0] elem_idx;
	logic       last_byte; // final LF handed over
	elem_t      next_byte;
	logic       fire;

	assign fire = (state == st_send) && !tx_busy;

	always_comb begin
		case (phase)
			ph_digit: next_byte = mat[elem_idx] + 8'h30;
			ph_space: next_byte = 8'h20;
			ph_cr:    next_byte = 8'h0d;
			default:  next_byte = 8'h0a;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && mbus.valid) begin
			mat   <= mbus.data;
			dim_m <= mbus.m;
			dim_n <= mbus.n;
		end
		if (fire)
			tx_data <= next_byte;
	end

	// ============================================================
	// byte sequencer
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= st_idle;
			phase     <= ph_digit;
			row       <= '0;
			col       <= '0;
			elem_idx  <= '0;
			last_byte <= 1'b0;
			tx_start  <= 1'b0;
			done      <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			done     <= 1'b0;
			case (state)
				st_idle: if (mbus.valid) begin  // busy printer drops new matrices
					row       <= '0;
					col       <= '0;
					elem_idx  <= '0;
					phase     <= ph_digit;
					last_byte <= 1'b0;
					state     <= st_send;
				end
				st_send: if (fire) begin
					tx_start <= 1'b1;
					state    <= st_wait_hi;
					case (phase)
						ph_digit: begin
							elem_idx <= elem_idx + 5'd1;
							phase    <= (col == dim_n - 3'd1) ? ph_cr : ph_space;
						end
						ph_space: begin
							col   <= col + 3'd1;
							phase <= ph_digit;
						end
						ph_cr: phase <= ph_lf;
						default: begin            // LF ends the row
							row       <= row + 3'd1;
							col       <= '0;
							phase     <= ph_digit;
							last_byte <= (row == dim_m - 3'd1);
						end
					endcase
				end
				st_wait_hi: if (tx_busy) begin  // transmitter took the byte
					done  <= last_byte;
					state <= last_byte ? st_idle : st_send;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- src/matrix_settings.svh
// shared constants for the matrix echo design, `include it wherever a value is needed
`ifndef MATRIX_SETTINGS_SVH
`define MATRIX_SETTINGS_SVH

// ============================================================
// clocking and serial line
// ============================================================
`define CLK_HZ            50000000
`define UART_CLKS_PER_BIT (`CLK_HZ / 115200)   // 434 clocks, 115200 baud
`define DEBOUNCE_CYCLES   16                    // short for simulation

// ============================================================
// matrix limits and status
// ============================================================
`define MAX_DIM           5                     // largest side
`define ELEM_MAX          9                     // largest digit accepted
`define STORE_SLOTS       2
`define BLINK_CYCLES      (`CLK_HZ / 2)         // half a second lit

`endif

//--- src/matrix_store.sv
// two-slot round-robin matrix memory with stored count and status blink timers
`timescale 1ns/10ps
`include "matrix_settings.svh"

module matrix_store (
	input  logic        clk,
	input  logic        rst_n,
	matrix_bus_if.dst   mbus,
	input  logic        parse_error,
	output logic [1:0]  stored_count,
	output logic        store_blink,
	output logic        error_blink
);
	import matrix_pkg::*;

	localparam int slot_w  = $clog2(`STORE_SLOTS);
	localparam int blink_w = $clog2(`BLINK_CYCLES);

	matrix_t           mem   [`STORE_SLOTS];
	dim_t              mem_m [`STORE_SLOTS];
	dim_t              mem_n [`STORE_SLOTS];
	logic [slot_w-1:0] wr_slot;           // next slot to overwrite
	logic              stored;            // write happened last clock
	logic [1:0]        trig;              // bit 0 store, bit 1 error
	logic [1:0]        blink_on;
	logic [blink_w-1:0] blink_cnt [2];

	assign trig        = {parse_error, stored};
	assign store_blink = blink_on[0];
	assign error_blink = blink_on[1];

	always_ff @(posedge clk)
		if (mbus.valid) begin
			mem[wr_slot]   <= mbus.data;
			mem_m[wr_slot] <= mbus.m;
			mem_n[wr_slot] <= mbus.n;
		end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_slot      <= '0;
			stored       <= 1'b0;
			stored_count <= '0;
			blink_on     <= '0;
			blink_cnt    <= '{default: '0};
		end else begin
			stored <= mbus.valid;
			if (mbus.valid)
				wr_slot <= (wr_slot == slot_w'(`STORE_SLOTS - 1)) ? '0 : wr_slot + 1'b1;
			if (stored && stored_count != 2'(`STORE_SLOTS))
				stored_count <= stored_count + 2'd1;     // saturates
			// retriggerable half-second timers
			for (int i = 0; i < 2; i++) begin
				if (trig[i]) begin
					blink_on[i]  <= 1'b1;
					blink_cnt[i] <= '0;
				end else if (blink_on[i]) begin
					if (blink_cnt[i] == blink_w'(`BLINK_CYCLES - 1))
						blink_on[i] <= 1'b0;
					else
						blink_cnt[i] <= blink_cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

//--- src/mode_controller.sv
// debounces confirm and exit buttons and holds the operating mode register
`timescale 1ns/10ps
`include "matrix_settings.svh"

module mode_controller (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [2:0]         command,
	input  logic               btn_confirm,
	input  logic               btn_exit,
	output matrix_pkg::mode_t  mode
);
	import matrix_pkg::*;

	localparam int db_w = $clog2(`DEBOUNCE_CYCLES + 1);

	logic [1:0]      btn_raw;     // bit 0 confirm, bit 1 exit
	logic [1:0]      sync0;
	logic [1:0]      sync1;
	logic [1:0]      stable;      // debounced level
	logic [db_w-1:0] cnt [2];
	logic [1:0]      press;       // rising edge of debounced level

	assign btn_raw = {btn_exit, btn_confirm};

	// press fires in the clock where stable flips to 1
	always_comb
		for (int i = 0; i < 2; i++)
			press[i] = sync1[i] && !stable[i] && cnt[i] == db_w'(`DEBOUNCE_CYCLES - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync0  <= '0;
			sync1  <= '0;
			stable <= '0;
			cnt    <= '{default: '0};
			mode   <= mode_idle;
		end else begin
			sync0 <= btn_raw;
			sync1 <= sync0;
			for (int i = 0; i < 2; i++) begin
				if (sync1[i] == stable[i])
					cnt[i] <= '0;                 // no change pending
				else if (cnt[i] == db_w'(`DEBOUNCE_CYCLES - 1)) begin
					stable[i] <= sync1[i];
					cnt[i]    <= '0;
				end else
					cnt[i] <= cnt[i] + 1'b1;
			end
			if (press[1])
				mode <= mode_idle;                // exit wins
			else if (press[0] && command == 3'd1)
				mode <= mode_data_input;
			else if (press[0] && command == 3'd0)
				mode <= mode_idle;                // other codes ignored
		end
	end

endmodule

//--- src/uart_rx.sv
// uart receiver 8N1, mid-bit sampling, strobes rx_done with each good byte
`timescale 1ns/10ps
`include "matrix_settings.svh"

module uart_rx (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               rxd,
	output logic               rx_done,
	output matrix_pkg::elem_t  rx_data
);
	localparam int full_bit = `UART_CLKS_PER_BIT;
	localparam int half_bit = `UART_CLKS_PER_BIT / 2;
	localparam int cnt_w    = $clog2(`UART_CLKS_PER_BIT);

	logic [1:0]       rxd_sync;  // two-flop synchronizer
	logic             busy;      // frame in progress
	logic [cnt_w-1:0] clk_cnt;
	logic [cnt_w-1:0] target;    // half bit for start, full bit after
	logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 stop
	logic [7:0]       shift;
	logic             sample;

	assign target = (bit_idx == 4'd0) ? cnt_w'(half_bit - 1) : cnt_w'(full_bit - 1);
	assign sample = busy && (clk_cnt == target);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_sync <= 2'b11; // idle line is high
			busy     <= 1'b0;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_done  <= 1'b0;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
			rx_done  <= 1'b0;
			if (!busy) begin
				if (!rxd_sync[1]) begin // falling edge, start bit
					busy    <= 1'b1;
					clk_cnt <= '0;
					bit_idx <= '0;
				end
			end else if (sample) begin
				clk_cnt <= '0;
				if (bit_idx == 4'd0 && rxd_sync[1])
					busy <= 1'b0;              // glitch, not a start bit
				else if (bit_idx == 4'd9) begin
					busy    <= 1'b0;
					rx_done <= rxd_sync[1];    // drop byte on framing error
				end else
					bit_idx <= bit_idx + 4'd1;
			end else
				clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// data path, lsb first
	always_ff @(posedge clk) begin
		if (sample && bit_idx != 4'd0 && bit_idx != 4'd9)
			shift <= {rxd_sync[1], shift[7:1]};
		if (sample && bit_idx == 4'd9)
			rx_data <= shift;
	end

endmodule

//--- src/uart_tx.sv
// uart transmitter 8N1, busy high from the clock after tx_start to the end of stop
`timescale 1ns/10ps
`include "matrix_settings.svh"

module uart_tx (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               tx_start,
	input  matrix_pkg::elem_t  tx_data,
	output logic               txd,
	output logic               busy
);
	localparam int cnt_w = $clog2(`UART_CLKS_PER_BIT);

	logic [cnt_w-1:0] clk_cnt;
	logic [3:0]       bit_idx; // bits already on the line
	logic [8:0]       frame;   // data then stop bit

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			txd     <= 1'b1;
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			txd <= 1'b1;
			if (tx_start) begin
				busy    <= 1'b1;
				txd     <= 1'b0; // start bit
				clk_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (clk_cnt == cnt_w'(`UART_CLKS_PER_BIT - 1)) begin
			clk_cnt <= '0;
			if (bit_idx == 4'd9)
				busy <= 1'b0;          // stop bit done
			else begin
				txd     <= frame[bit_idx];
				bit_idx <= bit_idx + 4'd1;
			end
		end else
			clk_cnt <= clk_cnt + 1'b1;
	end

	always_ff @(posedge clk)
		if (tx_start && !busy)
			frame <= {1'b1, tx_data};

endmodule

//--- verif/matrix_echo_tb.sv
// testbench for matrix_echo_top, replays verif/matrix_input.txt and checks echo and leds
`timescale 1ns/10ps
`include "matrix_settings.svh"

module matrix_echo_tb;

	localparam int byte_clks = 10 * `UART_CLKS_PER_BIT; // one 8N1 frame

	logic       clk;
	logic       rst_n;
	logic [2:0] command;
	logic       btn_confirm;
	logic       btn_exit;
	logic       uart_rxd;
	logic       uart_txd;
	logic [7:0] led;
	logic [7:0] ld2;

	logic [7:0] stim_q [$];  // bytes for uart_rxd
	logic [7:0] exp_q  [$];  // expected echo
	logic [7:0] tx_q   [$];  // decoded from uart_txd
	logic [7:0] op_q   [$];  // opcode per case
	string      text_q [$];  // characters per case
	integer     seed = 32'h2d97;
	int         num_cases = 0;
	int         checks = 0;
	int         mismatches = 0;
	int         failures = 0;   // timeouts, framing, stray bytes
	logic [1:0] exp_count = 2'd0; // model of the stored matrix count

	matrix_echo_top uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.command     (command),
		.btn_confirm (btn_confirm),
		.btn_exit    (btn_exit),
		.uart_rxd    (uart_rxd),
		.uart_txd    (uart_txd),
		.led         (led),
		.ld2         (ld2)
	);

	// ============================================================
	// clock, watchdog, tx monitor
	// ============================================================
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// 60 byte frames per case at 20 ns a clock, plus ten frames spare
	initial begin : watchdog
		longint limit_ns;
		wait (num_cases > 0);
		limit_ns = (longint'(num_cases) * 60 + 10) * byte_clks * 20;
		#(limit_ns);
		$display("watchdog expired after %0d ns, run did not finish", limit_ns);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin : tx_monitor
		logic [7:0] b;
		forever begin
			@(negedge clk);                   // txd moves on posedge
			if (rst_n && uart_txd === 1'b0) begin
				repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk); // mid start bit
				for (int i = 0; i < 8; i++) begin
					repeat (`UART_CLKS_PER_BIT) @(negedge clk);
					b[i] = uart_txd;              // lsb first
				end
				repeat (`UART_CLKS_PER_BIT) @(negedge clk);
				if (uart_txd !== 1'b1) begin
					failures++;
					$display("framing error on uart_txd, stop bit was low");
				end else
					tx_q.push_back(b);
			end
		end
	end

	// ============================================================
	// stimulus helpers
	// ============================================================
	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] want);
		checks++;
		if (got !== want) begin
			mismatches++;
			$display("MISMATCH %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};              // stop, data, start
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			uart_rxd <= frame[i];
			repeat (`UART_CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	// hold a button until led shows want_led, then release and let it settle
	task automatic press_button(input logic use_exit, input logic [7:0] want_led);
		int waited;
		waited = 0;
		@(posedge clk);
		if (use_exit)
			btn_exit <= 1'b1;
		else
			btn_confirm <= 1'b1;
		do begin
			@(negedge clk);
			waited++;
		end while (led !== want_led && waited < `DEBOUNCE_CYCLES + 10);
		check_value("led", led, want_led);
		@(posedge clk);
		btn_exit    <= 1'b0;
		btn_confirm <= 1'b0;
		repeat (`DEBOUNCE_CYCLES + 6) @(posedge clk);
	endtask

	// fresh reset, so count and blink leds start from zero again
	task automatic restart_dut();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		exp_count = 2'd0;
		@(negedge clk);
		check_value("ld2", ld2, 8'h00);
		press_button(1'b0, 8'h20);            // command still 1
	endtask

	function automatic void text_stim(input string text);
		stim_q.delete();
		for (int i = 0; i < text.len(); i++)
			if (text[i] != 8'h0a && text[i] != 8'h0d) // line ends stay in the file
				stim_q.push_back(text[i]);
	endfunction

	// m, n and digits drawn in range, space separated
	function automatic void random_stim();
		int m;
		int n;
		stim_q.delete();
		m = 1 + int'($unsigned($random(seed)) % `MAX_DIM);
		n = 1 + int'($unsigned($random(seed)) % `MAX_DIM);
		stim_q.push_back(8'(m + 48));
		stim_q.push_back(8'h20);
		stim_q.push_back(8'(n + 48));
		for (int i = 0; i < m * n; i++) begin
			stim_q.push_back(8'h20);
			stim_q.push_back(8'(int'($unsigned($random(seed)) % (`ELEM_MAX + 1)) + 48));
		end
	endfunction

	// rows of digits with single spaces, CR LF after each row
	function automatic void build_echo();
		int digits [$];
		int m;
		int n;
		exp_q.delete();
		foreach (stim_q[i])
			if (stim_q[i] >= 8'h30 && stim_q[i] <= 8'h39)
				digits.push_back(int'(stim_q[i]) - 48);
		m = digits[0];
		n = digits[1];
		for (int r = 0; r < m; r++) begin
			for (int c = 0; c < n; c++) begin
				exp_q.push_back(8'(digits[2 + r * n + c] + 48));
				if (c < n - 1)
					exp_q.push_back(8'h20);
			end
			exp_q.push_back(8'h0d);
			exp_q.push_back(8'h0a);
		end
	endfunction

	task automatic collect_echo();
		int         waited;
		int         limit;
		logic [7:0] got;
		waited = 0;
		limit  = (exp_q.size() + 2) * byte_clks;
		while (tx_q.size() < exp_q.size() && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (tx_q.size() < exp_q.size()) begin
			failures++;
			$display("echo timed out, %0d of %0d bytes seen", tx_q.size(), exp_q.size());
		end
		for (int i = 0; i < exp_q.size() && tx_q.size() > 0; i++) begin
			got = tx_q.pop_front();
			checks++;
			if (got !== exp_q[i]) begin
				mismatches++;
				$display("MISMATCH uart_txd byte %0d: got %h expected %h", i, got, exp_q[i]);
			end
		end
	endtask

	task automatic run_case(input logic [7:0] op, input string text);
		if (op == "S")
			random_stim();
		else
			text_stim(text);
		if (op == "E" || op == "I")
			restart_dut();                    // count and error blink back at zero
		if (op == "I")
			press_button(1'b1, 8'h00);        // back to idle first
		foreach (stim_q[i])
			send_byte(stim_q[i]);
		repeat (8) @(negedge clk);            // status leds settle
		if (op == "M" || op == "S") begin
			build_echo();
			collect_echo();
			if (exp_count != 2'(`STORE_SLOTS))
				exp_count++;                      // count saturates
			check_value("ld2[0]", 8'(ld2[0]), 8'h01);
		end else if (op == "E")
			check_value("ld2[1]", 8'(ld2[1]), 8'h01);
		check_value("ld2[3:2]", 8'(ld2[3:2]), 8'(exp_count));
		repeat (2 * byte_clks) @(negedge clk);
		if (tx_q.size() != 0) begin
			failures++;
			$display("%0d unexpected bytes on uart_txd after case %s", tx_q.size(), text);
			tx_q.delete();
		end
		if (op == "I")
			press_button(1'b0, 8'h20);        // command still 1
	endtask

	task automatic read_cases();
		int    fd;
		int    rc;
		string line;
		fd = $fopen("verif/matrix_input.txt", "r");
		if (fd == 0) begin
			failures++;
			$display("could not open verif/matrix_input.txt");
			return;
		end
		while (!$feof(fd)) begin
			rc = $fgets(line, fd);
			if (rc > 2 && line[0] != 8'h23) begin // skip # lines
				op_q.push_back(line[0]);
				text_q.push_back(line.substr(2, line.len() - 1));
			end
		end
		$fclose(fd);
		num_cases = op_q.size();
	endtask

	// ============================================================
	// main sequence
	// ============================================================
	initial begin : main
		rst_n       = 1'b0;
		command     = 3'd0;
		btn_confirm = 1'b0;
		btn_exit    = 1'b0;
		uart_rxd    = 1'b1;                   // idle line
		read_cases();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("uart_txd", 8'(uart_txd), 8'h01);
		check_value("led", led, 8'h00);
		check_value("ld2", ld2, 8'h00);
		@(posedge clk);
		command <= 3'd1;                      // data input
		press_button(1'b0, 8'h20);
		press_button(1'b1, 8'h00);
		press_button(1'b0, 8'h20);
		foreach (op_q[k])
			run_case(op_q[k], text_q[k]);
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- verif/matrix_input.txt
# opcode then the characters sent on uart_rxd, one case per line
# M valid matrix, E bad line, I sent while idle, S random valid matrix (text ignored)
M 1 1 7
M 2 3 1 2 3 4 5 6
M 3 3 987654321
E 2 2 1 x
M 5 5 1 2 3 4 5 6 7 8 9 0 1 2 3 4 5 6 7 8 9 0 1 2 3 4 5
E 0
E 3 6
S -
I 2 2 1 2 3 4
M 4 2 0 1 2 3 4 5 6 7
S -
E 2 2 5 :
